// ==== Makefile ====
# Verilator build and run of the FP register read path testbench

VERILATOR ?= verilator
TOP ?= fpRegReadTb
FILELIST ?= compile.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -j 0
PASS_TEXT ?= Regression passed

SIM := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard verilog/*.svh)

.PHONY: all build run clean

all: run

build: $(SIM)

# Rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# Pass only if the pass line shows up in the output
run: $(SIM)
	@out="$$($(SIM) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

// ==== compile.f ====
+incdir+verilog
verilog/fpRegReadPkg.sv
verilog/fpRegisterFile.sv
verilog/fpRegisterReadStage.sv
verilog/fpExecuteLatch.sv
verilog/fpRegReadTop.sv
dv/fpRegReadTb.sv

// ==== dv/fpRegReadTb.sv ====
////////////////////
// Random testbench for the FP register read path
// Model tracks register values, ready bits and the stage
// Expected outputs follow the fixed two-edge latency
////////////////////
`include "fpRegRead_consts.svh"

module fpRegReadTb;

    localparam int TEST_CYCLES = 3000;
    localparam int TIMEOUT_CYCLES = TEST_CYCLES * 4 / 3;
    localparam int RESET_CYCLES = 4;

    // Expected latch contents of one lane
    typedef struct packed {
        logic valid;
        logic replay;
        logic divRel;
        fpRegReadPkg::FpIssuedOp op;
        fpRegReadPkg::FpOperand [`FP_SRC_NUM-1:0] operand;
    } ExpLane;

    logic clk;
    logic reset;
    logic stall;
    logic clear;
    logic issueValid [`FP_ISSUE_WIDTH];
    fpRegReadPkg::FpIssuedOp issueOp [`FP_ISSUE_WIDTH];
    logic flushActive;
    logic flushAll;
    fpRegReadPkg::ActiveListPtr flushHead;
    fpRegReadPkg::ActiveListPtr flushTail;
    logic wbValid [`FP_ISSUE_WIDTH];
    fpRegReadPkg::PRegNum wbReg [`FP_ISSUE_WIDTH];
    fpRegReadPkg::FpData wbData [`FP_ISSUE_WIDTH];
    logic allocValid;
    fpRegReadPkg::PRegNum allocReg;

    logic exValid [`FP_ISSUE_WIDTH];
    logic exReplay [`FP_ISSUE_WIDTH];
    fpRegReadPkg::FpIssuedOp exOp [`FP_ISSUE_WIDTH];
    fpRegReadPkg::FpOperand exOperand [`FP_ISSUE_WIDTH][`FP_SRC_NUM];
    logic divRelease [`FP_ISSUE_WIDTH];

    // Reference register file and stage register
    fpRegReadPkg::FpData refVal [`FP_PREG_NUM];
    logic refReady [`FP_PREG_NUM];
    logic stageValid [`FP_ISSUE_WIDTH];
    fpRegReadPkg::FpIssuedOp stageOp [`FP_ISSUE_WIDTH];
    ExpLane expNow [`FP_ISSUE_WIDTH];

    int cycleCount = 0;
    int replaySeen = 0;
    int divSeen = 0;
    int fwdSeen = 0;
    int flushAllSeen = 0;
    int wrapSeen = 0;
    int stallSeen = 0;
    int clearSeen = 0;

    fpRegReadTop DUT (
        .clk(clk),
        .reset(reset),
        .stall(stall),
        .clear(clear),
        .issueValid(issueValid),
        .issueOp(issueOp),
        .flushActive(flushActive),
        .flushAll(flushAll),
        .flushHead(flushHead),
        .flushTail(flushTail),
        .wbValid(wbValid),
        .wbReg(wbReg),
        .wbData(wbData),
        .allocValid(allocValid),
        .allocReg(allocReg),
        .exValid(exValid),
        .exReplay(exReplay),
        .exOp(exOp),
        .exOperand(exOperand),
        .divRelease(divRelease)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount > TIMEOUT_CYCLES) begin
            failRun("Run did not finish within the cycle limit");
        end
    end

    task automatic failRun(input string reason);
        $display("%s", reason);
        $display("Regression failed");
        $fatal(1);
    endtask

    task automatic checkValue(input string name, input logic [63:0] expected,
                              input logic [63:0] actual);
        assert (actual === expected) else begin
            failRun($sformatf("[ERROR] %s expected 0x%h actual 0x%h", name, expected, actual));
        end
    endtask

    // Walk the active list from head to tail, wrapping at the end
    function automatic logic flushCovers(input fpRegReadPkg::ActiveListPtr ptr);
        fpRegReadPkg::ActiveListPtr idx;
        logic hit;
        hit = 1'b0;
        idx = flushHead;
        while (idx != flushTail) begin
            if (idx == ptr) begin
                hit = 1'b1;
            end
            idx = idx + 1'b1;
        end
        return flushActive && (flushAll || hit);
    endfunction

    function automatic fpRegReadPkg::FpOperand readOperand(
        input fpRegReadPkg::FpIssuedOp op,
        input int s,
        output logic forwarded
    );
        fpRegReadPkg::FpOperand result;
        fpRegReadPkg::PRegNum regNum;
        forwarded = 1'b0;
        regNum = op.src[s].regNum;
        if (op.operandType[s] == fpRegReadPkg::OOT_IMM) begin
            result.data = {{(`FP_DATA_WIDTH - `FP_PREG_NUM_WIDTH){1'b0}}, op.src[s].imm};
            result.ready = 1'b1;
        end else begin
            result.data = refVal[regNum];
            result.ready = refReady[regNum];
            // Lane 1 checked last, so it wins a double write-back
            for (int w = 0; w < `FP_ISSUE_WIDTH; w++) begin
                if (wbValid[w] && wbReg[w] == regNum) begin
                    result.data = wbData[w];
                    result.ready = 1'b1;
                    forwarded = 1'b1;
                end
            end
        end
        return result;
    endfunction

    function automatic fpRegReadPkg::FpIssuedOp randomOp();
        fpRegReadPkg::FpIssuedOp op;
        op.opType = fpRegReadPkg::FpOpType'($urandom_range(0, 5));
        for (int s = 0; s < `FP_SRC_NUM; s++) begin
            op.operandType[s] = ($urandom_range(0, 3) == 0) ? fpRegReadPkg::OOT_IMM
                                                            : fpRegReadPkg::OOT_REG;
            op.src[s].regNum = fpRegReadPkg::PRegNum'($urandom);
        end
        op.writeReg = ($urandom_range(0, 1) == 1);
        op.dstReg = fpRegReadPkg::PRegNum'($urandom);
        op.activeListPtr = fpRegReadPkg::ActiveListPtr'($urandom);
        return op;
    endfunction

    // Latch contents after the coming edge, from the inputs applied now
    task automatic predictLane(input int i);
        fpRegReadPkg::FpOperand [`FP_SRC_NUM-1:0] operand;
        logic allReady;
        logic flushed;
        logic live;
        logic forwarded;
        logic anyFwd;
        allReady = 1'b1;
        anyFwd = 1'b0;
        for (int s = 0; s < `FP_SRC_NUM; s++) begin
            operand[s] = readOperand(stageOp[i], s, forwarded);
            allReady = allReady && operand[s].ready;
            anyFwd = anyFwd || forwarded;
        end
        flushed = stageValid[i] && flushCovers(stageOp[i].activeListPtr);
        live = stageValid[i] && !clear && !flushed;

        if (reset) begin
            expNow[i].valid = 1'b0;
            expNow[i].replay = 1'b0;
            expNow[i].divRel = 1'b0;
        end else begin
            expNow[i].divRel = flushed && !stall &&
                (stageOp[i].opType == fpRegReadPkg::FP_OP_DIV ||
                 stageOp[i].opType == fpRegReadPkg::FP_OP_SQRT);
            if (!stall) begin
                expNow[i].valid = live && allReady;
                expNow[i].replay = live && !allReady;
                if (live && anyFwd) fwdSeen++;
                if (flushed && flushAll) flushAllSeen++;
                if (flushed && !flushAll && flushHead > flushTail) wrapSeen++;
                if (stageValid[i] && clear && !flushed) clearSeen++;
            end else if (expNow[i].valid) begin
                stallSeen++;
            end
        end
        if (!stall) begin
            expNow[i].op = stageOp[i];
            expNow[i].operand = operand;
        end
        if (expNow[i].replay) replaySeen++;
        if (expNow[i].divRel) divSeen++;
    endtask

    task automatic updateModel();
        if (reset) begin
            for (int r = 0; r < `FP_PREG_NUM; r++) begin
                refVal[r] = '0;
                refReady[r] = 1'b1;
            end
        end else begin
            if (allocValid) begin
                refReady[allocReg] = 1'b0;
            end
            for (int w = 0; w < `FP_ISSUE_WIDTH; w++) begin
                if (wbValid[w]) begin
                    refVal[wbReg[w]] = wbData[w];
                    refReady[wbReg[w]] = 1'b1;
                end
            end
        end
        for (int i = 0; i < `FP_ISSUE_WIDTH; i++) begin
            if (reset) begin
                stageValid[i] = 1'b0;
            end else if (!stall) begin
                stageValid[i] = issueValid[i];
            end
            if (!stall) begin
                stageOp[i] = issueOp[i];
            end
        end
    endtask

    task automatic driveInputs(input logic nextReset);
        int pick;
        reset <= nextReset;
        // An op offered during a stall stays on the issue port
        if (!stall) begin
            for (int i = 0; i < `FP_ISSUE_WIDTH; i++) begin
                issueValid[i] <= ($urandom_range(0, 3) != 0);
                issueOp[i] <= randomOp();
            end
        end
        stall <= ($urandom_range(0, 9) == 0);
        clear <= ($urandom_range(0, 11) == 0);
        flushActive <= ($urandom_range(0, 4) == 0);
        flushAll <= ($urandom_range(0, 3) == 0);
        flushHead <= fpRegReadPkg::ActiveListPtr'($urandom);
        flushTail <= fpRegReadPkg::ActiveListPtr'($urandom);
        for (int w = 0; w < `FP_ISSUE_WIDTH; w++) begin
            pick = $urandom_range(0, `FP_SRC_NUM - 1);
            wbValid[w] <= ($urandom_range(0, 2) == 0);
            // Half the write-backs hit a source of the op now in the stage
            if ($urandom_range(0, 1) == 0) begin
                wbReg[w] <= stageOp[w].src[pick].regNum;
            end else begin
                wbReg[w] <= fpRegReadPkg::PRegNum'($urandom);
            end
            wbData[w] <= {$urandom, $urandom};
        end
        allocValid <= ($urandom_range(0, 1) == 0);
        allocReg <= fpRegReadPkg::PRegNum'($urandom);
    endtask

    task automatic checkOutputs();
        for (int i = 0; i < `FP_ISSUE_WIDTH; i++) begin
            checkValue($sformatf("exValid[%0d]", i), 64'(expNow[i].valid), 64'(exValid[i]));
            checkValue($sformatf("exReplay[%0d]", i), 64'(expNow[i].replay),
                       64'(exReplay[i]));
            checkValue($sformatf("divRelease[%0d]", i), 64'(expNow[i].divRel),
                       64'(divRelease[i]));
            if (expNow[i].valid || expNow[i].replay) begin
                checkValue($sformatf("exOp[%0d]", i), 64'(expNow[i].op), 64'(exOp[i]));
                for (int s = 0; s < `FP_SRC_NUM; s++) begin
                    checkValue($sformatf("exOperand[%0d][%0d].data", i, s),
                               expNow[i].operand[s].data, exOperand[i][s].data);
                    checkValue($sformatf("exOperand[%0d][%0d].ready", i, s),
                               64'(expNow[i].operand[s].ready), 64'(exOperand[i][s].ready));
                end
            end
        end
    endtask

    task automatic noteMissing(input string what, input int count, inout int missed);
        if (count == 0) begin
            $display("Stimulus never reached: %s", what);
            missed++;
        end
    endtask

    initial begin
        int missed;
        void'($urandom(32'hd091));
        reset = 1'b1;
        stall = 1'b0;
        clear = 1'b0;
        flushActive = 1'b0;
        flushAll = 1'b0;
        flushHead = '0;
        flushTail = '0;
        allocValid = 1'b0;
        allocReg = '0;
        for (int i = 0; i < `FP_ISSUE_WIDTH; i++) begin
            issueValid[i] = 1'b0;
            issueOp[i] = '0;
            wbValid[i] = 1'b0;
            wbReg[i] = '0;
            wbData[i] = '0;
            stageValid[i] = 1'b0;
            stageOp[i] = '0;
            expNow[i] = '0;
        end
        for (int r = 0; r < `FP_PREG_NUM; r++) begin
            refVal[r] = '0;
            refReady[r] = 1'b1;
        end

        for (int cyc = 1; cyc <= TEST_CYCLES; cyc++) begin
            @(posedge clk);
            for (int i = 0; i < `FP_ISSUE_WIDTH; i++) begin
                predictLane(i);
            end
            updateModel();
            driveInputs(cyc < RESET_CYCLES);
            @(negedge clk);
            checkOutputs();
        end

        missed = 0;
        noteMissing("replay of a not-ready operand", replaySeen, missed);
        noteMissing("divider release pulse", divSeen, missed);
        noteMissing("write-through forwarding", fwdSeen, missed);
        noteMissing("flush of all entries", flushAllSeen, missed);
        noteMissing("wrapping flush range", wrapSeen, missed);
        noteMissing("valid op held by stall", stallSeen, missed);
        noteMissing("op dropped by clear", clearSeen, missed);
        if (missed == 0) begin
            $display("Regression passed");
            $finish;
        end else begin
            failRun("Random stimulus missed at least one behavior");
        end
    end

endmodule

// ==== verilog/fpExecuteLatch.sv ====
////////////////////
// Execute-side latch of the FP read path
// Not-ready operands turn the op into a replay
// divRelease is a pulse and is not held by stall
////////////////////
`include "fpRegRead_consts.svh"

module fpExecuteLatch (
    input  logic clk,
    input  logic reset,
    input  logic stall,

    // From the read stage
    input  logic rrValid [`FP_ISSUE_WIDTH],
    input  fpRegReadPkg::FpIssuedOp rrOp [`FP_ISSUE_WIDTH],
    input  fpRegReadPkg::FpOperand rrOperand [`FP_ISSUE_WIDTH][`FP_SRC_NUM],
    input  logic rrFlushed [`FP_ISSUE_WIDTH],

    // To execution
    output logic exValid [`FP_ISSUE_WIDTH],
    output logic exReplay [`FP_ISSUE_WIDTH],
    output fpRegReadPkg::FpIssuedOp exOp [`FP_ISSUE_WIDTH],
    output fpRegReadPkg::FpOperand exOperand [`FP_ISSUE_WIDTH][`FP_SRC_NUM],
    output logic divRelease [`FP_ISSUE_WIDTH]
);

    logic allReady [`FP_ISSUE_WIDTH];

    always_comb begin
        for (int i = 0; i < `FP_ISSUE_WIDTH; i++) begin
            allReady[i] = 1'b1;
            for (int s = 0; s < `FP_SRC_NUM; s++) begin
                allReady[i] = allReady[i] && rrOperand[i][s].ready;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `FP_ISSUE_WIDTH; i++) begin
                exValid[i] <= 1'b0;
                exReplay[i] <= 1'b0;
                divRelease[i] <= 1'b0;
            end
        end else begin
            for (int i = 0; i < `FP_ISSUE_WIDTH; i++) begin
                divRelease[i] <= rrFlushed[i];
                if (!stall) begin
                    exValid[i] <= rrValid[i] && allReady[i];
                    exReplay[i] <= rrValid[i] && !allReady[i];
                end
            end
        end
    end

    // Op and operand payload
    always_ff @(posedge clk) begin
        if (!stall) begin
            exOp <= rrOp;
            exOperand <= rrOperand;
        end
    end

endmodule

// ==== verilog/fpRegReadPkg.sv ====
////////////////////
// Micro-op and operand types for the FP read path
// A source word is a register number or a 5-bit
// immediate, chosen by that source's operand type
////////////////////
`include "fpRegRead_consts.svh"

package fpRegReadPkg;

    typedef logic [`FP_PREG_NUM_WIDTH-1:0] PRegNum;
    typedef logic [`FP_DATA_WIDTH-1:0] FpData;
    typedef logic [`ACTIVE_LIST_WIDTH-1:0] ActiveListPtr;

    typedef enum logic {
        OOT_REG = 1'b0,
        OOT_IMM = 1'b1
    } OperandType;

    typedef enum logic [2:0] {
        FP_OP_ADD  = 3'd0,
        FP_OP_MUL  = 3'd1,
        FP_OP_FMA  = 3'd2,
        FP_OP_DIV  = 3'd3,
        FP_OP_SQRT = 3'd4,
        FP_OP_MOVE = 3'd5
    } FpOpType;

    // Same 5 bits, two readings
    typedef union packed {
        PRegNum regNum;
        logic [`FP_PREG_NUM_WIDTH-1:0] imm;
    } SrcField;

    typedef struct packed {
        FpOpType opType;
        OperandType [`FP_SRC_NUM-1:0] operandType;
        SrcField [`FP_SRC_NUM-1:0] src;
        logic writeReg;
        PRegNum dstReg;
        ActiveListPtr activeListPtr;
    } FpIssuedOp;

    typedef struct packed {
        FpData data;
        logic ready;
    } FpOperand;

    // Range runs from head up to but not including tail,
    // wrapping past the last entry; head equal to tail is empty
    function automatic logic inFlushRange(
        input logic flushActive,
        input logic flushAll,
        input ActiveListPtr head,
        input ActiveListPtr tail,
        input ActiveListPtr ptr
    );
        logic inRange;
        if (head <= tail) begin
            inRange = (ptr >= head) && (ptr < tail);
        end else begin
            inRange = (ptr >= head) || (ptr < tail);
        end
        return flushActive && (flushAll || inRange);
    endfunction

endpackage

// ==== verilog/fpRegReadTop.sv ====
////////////////////
// FP register read path, issue to execute
// Two-edge latency from issue to the ex outputs
////////////////////
`include "fpRegRead_consts.svh"

module fpRegReadTop (
    input  logic clk,
    input  logic reset,
    input  logic stall,
    input  logic clear,

    input  logic issueValid [`FP_ISSUE_WIDTH],
    input  fpRegReadPkg::FpIssuedOp issueOp [`FP_ISSUE_WIDTH],

    input  logic flushActive,
    input  logic flushAll,
    input  fpRegReadPkg::ActiveListPtr flushHead,
    input  fpRegReadPkg::ActiveListPtr flushTail,

    input  logic wbValid [`FP_ISSUE_WIDTH],
    input  fpRegReadPkg::PRegNum wbReg [`FP_ISSUE_WIDTH],
    input  fpRegReadPkg::FpData wbData [`FP_ISSUE_WIDTH],
    input  logic allocValid,
    input  fpRegReadPkg::PRegNum allocReg,

    output logic exValid [`FP_ISSUE_WIDTH],
    output logic exReplay [`FP_ISSUE_WIDTH],
    output fpRegReadPkg::FpIssuedOp exOp [`FP_ISSUE_WIDTH],
    output fpRegReadPkg::FpOperand exOperand [`FP_ISSUE_WIDTH][`FP_SRC_NUM],
    output logic divRelease [`FP_ISSUE_WIDTH]
);

    // Stage to register file
    fpRegReadPkg::PRegNum readReg [`FP_ISSUE_WIDTH][`FP_SRC_NUM];
    fpRegReadPkg::FpOperand regData [`FP_ISSUE_WIDTH][`FP_SRC_NUM];

    // Stage to latch
    logic rrValid [`FP_ISSUE_WIDTH];
    fpRegReadPkg::FpIssuedOp rrOp [`FP_ISSUE_WIDTH];
    fpRegReadPkg::FpOperand rrOperand [`FP_ISSUE_WIDTH][`FP_SRC_NUM];
    logic rrFlushed [`FP_ISSUE_WIDTH];

    fpRegisterReadStage stage (
        .clk(clk),
        .reset(reset),
        .stall(stall),
        .clear(clear),
        .issueValid(issueValid),
        .issueOp(issueOp),
        .flushActive(flushActive),
        .flushAll(flushAll),
        .flushHead(flushHead),
        .flushTail(flushTail),
        .readReg(readReg),
        .regData(regData),
        .rrValid(rrValid),
        .rrOp(rrOp),
        .rrOperand(rrOperand),
        .rrFlushed(rrFlushed)
    );

    fpRegisterFile regFile (
        .clk(clk),
        .reset(reset),
        .readReg(readReg),
        .regData(regData),
        .wbValid(wbValid),
        .wbReg(wbReg),
        .wbData(wbData),
        .allocValid(allocValid),
        .allocReg(allocReg)
    );

    fpExecuteLatch exLatch (
        .clk(clk),
        .reset(reset),
        .stall(stall),
        .rrValid(rrValid),
        .rrOp(rrOp),
        .rrOperand(rrOperand),
        .rrFlushed(rrFlushed),
        .exValid(exValid),
        .exReplay(exReplay),
        .exOp(exOp),
        .exOperand(exOperand),
        .divRelease(divRelease)
    );

endmodule

// ==== verilog/fpRegRead_consts.svh ====
////////////////////
// Sizes for the FP register read path
// Register number and immediate share one width
// Active-list size is a power of two
////////////////////
`ifndef FP_REG_READ_CONSTS_SVH
`define FP_REG_READ_CONSTS_SVH

// Issue lanes into the read stage
`define FP_ISSUE_WIDTH 2

// Source operands per micro-op
`define FP_SRC_NUM 3

// Physical FP registers
`define FP_PREG_NUM 32
`define FP_PREG_NUM_WIDTH 5

// Register word
`define FP_DATA_WIDTH 64

// Active-list pointer, 16 entries
`define ACTIVE_LIST_WIDTH 4

`endif

// ==== verilog/fpRegisterFile.sv ====
////////////////////
// Physical FP registers with ready bits
// Reads forward same-cycle write-back data
// Two write-backs to one register: the higher lane wins
////////////////////
`include "fpRegRead_consts.svh"

module fpRegisterFile (
    input  logic clk,
    input  logic reset,

    // Read ports, one per source per lane
    input  fpRegReadPkg::PRegNum readReg [`FP_ISSUE_WIDTH][`FP_SRC_NUM],
    output fpRegReadPkg::FpOperand regData [`FP_ISSUE_WIDTH][`FP_SRC_NUM],

    // Write-back
    input  logic wbValid [`FP_ISSUE_WIDTH],
    input  fpRegReadPkg::PRegNum wbReg [`FP_ISSUE_WIDTH],
    input  fpRegReadPkg::FpData wbData [`FP_ISSUE_WIDTH],

    // Allocation from rename
    input  logic allocValid,
    input  fpRegReadPkg::PRegNum allocReg
);

    fpRegReadPkg::FpData regWord [`FP_PREG_NUM];
    logic [`FP_PREG_NUM-1:0] regReady;

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int r = 0; r < `FP_PREG_NUM; r++) begin
                regWord[r] <= '0;
            end
            regReady <= '1;
        end else begin
            if (allocValid) begin
                regReady[allocReg] <= 1'b0;
            end
            // Later assignment, so write-back beats allocate
            for (int w = 0; w < `FP_ISSUE_WIDTH; w++) begin
                if (wbValid[w]) begin
                    regWord[wbReg[w]] <= wbData[w];
                    regReady[wbReg[w]] <= 1'b1;
                end
            end
        end
    end

    always_comb begin
        for (int i = 0; i < `FP_ISSUE_WIDTH; i++) begin
            for (int s = 0; s < `FP_SRC_NUM; s++) begin
                regData[i][s].data = regWord[readReg[i][s]];
                regData[i][s].ready = regReady[readReg[i][s]];

                // Write-through from this cycle's write-back
                for (int w = 0; w < `FP_ISSUE_WIDTH; w++) begin
                    if (wbValid[w] && wbReg[w] == readReg[i][s]) begin
                        regData[i][s].data = wbData[w];
                        regData[i][s].ready = 1'b1;
                    end
                end
            end
        end
    end

endmodule

// ==== verilog/fpRegisterReadStage.sv ====
////////////////////
// FP register read stage
// Flush is checked while the op sits in the stage register
// rrValid is low during stall, so the next latch holds
////////////////////
`include "fpRegRead_consts.svh"

module fpRegisterReadStage (
    input  logic clk,
    input  logic reset,
    input  logic stall,
    input  logic clear,

    // From issue
    input  logic issueValid [`FP_ISSUE_WIDTH],
    input  fpRegReadPkg::FpIssuedOp issueOp [`FP_ISSUE_WIDTH],

    // Recovery
    input  logic flushActive,
    input  logic flushAll,
    input  fpRegReadPkg::ActiveListPtr flushHead,
    input  fpRegReadPkg::ActiveListPtr flushTail,

    // Register file
    output fpRegReadPkg::PRegNum readReg [`FP_ISSUE_WIDTH][`FP_SRC_NUM],
    input  fpRegReadPkg::FpOperand regData [`FP_ISSUE_WIDTH][`FP_SRC_NUM],

    // To the execute latch
    output logic rrValid [`FP_ISSUE_WIDTH],
    output fpRegReadPkg::FpIssuedOp rrOp [`FP_ISSUE_WIDTH],
    output fpRegReadPkg::FpOperand rrOperand [`FP_ISSUE_WIDTH][`FP_SRC_NUM],
    output logic rrFlushed [`FP_ISSUE_WIDTH]
);

    logic pipeValid [`FP_ISSUE_WIDTH];
    fpRegReadPkg::FpIssuedOp pipeOp [`FP_ISSUE_WIDTH];

    logic flush [`FP_ISSUE_WIDTH];
    logic isDivSqrt [`FP_ISSUE_WIDTH];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `FP_ISSUE_WIDTH; i++) begin
                pipeValid[i] <= 1'b0;
            end
        end else if (!stall) begin
            pipeValid <= issueValid;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            pipeOp <= issueOp;
        end
    end

    always_comb begin
        for (int i = 0; i < `FP_ISSUE_WIDTH; i++) begin
            flush[i] = fpRegReadPkg::inFlushRange(
                flushActive,
                flushAll,
                flushHead,
                flushTail,
                pipeOp[i].activeListPtr
            );
            isDivSqrt[i] = pipeOp[i].opType inside {
                fpRegReadPkg::FP_OP_DIV,
                fpRegReadPkg::FP_OP_SQRT
            };

            for (int s = 0; s < `FP_SRC_NUM; s++) begin
                readReg[i][s] = pipeOp[i].src[s].regNum;
                if (pipeOp[i].operandType[s] == fpRegReadPkg::OOT_REG) begin
                    rrOperand[i][s] = regData[i][s];
                end else begin
                    // Immediates are always ready
                    rrOperand[i][s].data = fpRegReadPkg::FpData'(pipeOp[i].src[s].imm);
                    rrOperand[i][s].ready = 1'b1;
                end
            end

            rrValid[i] = pipeValid[i] && !(stall || clear || flush[i]);

            // A flushed div or sqrt gives back its divider slot.
            // Only once the stage moves, so the pulse is not repeated
            rrFlushed[i] = pipeValid[i] && flush[i] && isDivSqrt[i] && !stall;

            rrOp[i] = pipeOp[i];
        end
    end

endmodule
